// ==== common/sysPkg.sv ====
package sysPkg;

    localparam int WordWidth = 32;

    typedef logic [WordWidth-1:0] wordT;

    // Data side of the core, read data comes back separately
    typedef struct packed {
        wordT addr;
        wordT wdata;
        logic write;   // One-cycle strobe
    } dataBusT;

    // Host port for filling the instruction memory
    typedef struct packed {
        logic we;
        wordT addr;
        wordT data;
    } progLoadT;

endpackage

// ==== common/isaPkg.sv ====
package isaPkg;

    // Instruction word layout
    localparam int ImmTypeBit  = 30;
    localparam int StoringBit  = 29;
    localparam int DerefRhsBit = 28;
    localparam int RegZLsb     = 24;
    localparam int RegXLsb     = 20;
    localparam int RegYLsb     = 16;
    localparam int OpLsb       = 12;
    localparam int ImmLsb      = 0;
    localparam int ImmWidth    = 12;

    typedef logic [3:0] regIdxT;

    localparam regIdxT RegZero = 4'd0;   // Always reads as zero
    localparam regIdxT RegPc   = 4'd15;  // Reads as next program counter

    typedef enum logic [3:0] {
        OpOr, OpAnd, OpAdd, OpMul, OpResv4, OpShl, OpLt, OpEq,
        OpGt, OpAndNot, OpXor, OpSub, OpXnor, OpShr, OpNe, OpResv15
    } aluOpT;

    typedef struct packed {
        logic        immType;   // Immediate is the right operand
        logic        storing;
        logic        derefRhs;
        regIdxT      regZ;
        regIdxT      regX;
        regIdxT      regY;
        aluOpT       op;
        logic [31:0] imm;       // Sign-extended
        logic        illegal;
        logic        branch;    // Z is the PC and nothing is stored
    } decodedT;

    localparam logic [31:0] InsnNoop    = 32'h0000_0000;  // or into r0, discarded
    localparam logic [31:0] InsnIllegal = 32'hffff_ffff;

endpackage

// ==== core/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import isaPkg::*, sysPkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   en,
    input  logic   writeEn,
    input  regIdxT idxZ,
    input  regIdxT idxX,
    input  regIdxT idxY,
    input  wordT   writeData,
    input  wordT   nextPc,
    output wordT   valueZ,
    output wordT   valueX,
    output wordT   valueY
);

    wordT [14:1] store;  // r1..r14 only
    logic        isStorageZ;
    logic        doWrite;

    function automatic wordT readPort(regIdxT idx, wordT pcValue, wordT [14:1] regs);
        if (idx == RegZero) begin
            return '0;
        end
        if (idx == RegPc) begin
            return pcValue;
        end
        return regs[idx];
    endfunction

    assign valueX = readPort(idxX, nextPc, store);
    assign valueY = readPort(idxY, nextPc, store);
    assign valueZ = readPort(idxZ, nextPc, store);

    assign isStorageZ = (idxZ != RegZero) && (idxZ != RegPc);
    assign doWrite    = en && writeEn && isStorageZ;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            store[idxZ] <= writeData;
        end
    end

    // Writes aimed at r0 or the PC alias leave every register untouched
    assert property (@(posedge clk) disable iff (!reset_n)
        (en && writeEn && !isStorageZ) |=> (store == $past(store)))
        else $error("register file changed on a write to an alias index");

endmodule

// ==== core/insnDecode.sv ====
`timescale 1ns/1ps

module insnDecode
    import isaPkg::*, sysPkg::*;
(
    input  wordT    insn,
    output decodedT dec
);

    logic [ImmWidth-1:0] rawImm;
    regIdxT              fieldZ;
    logic                fieldStoring;

    assign rawImm       = insn[ImmLsb +: ImmWidth];
    assign fieldZ       = insn[RegZLsb +: $bits(regIdxT)];
    assign fieldStoring = insn[StoringBit];

    always_comb begin
        dec.immType  = insn[ImmTypeBit];
        dec.storing  = fieldStoring;
        dec.derefRhs = insn[DerefRhsBit];
        dec.regZ     = fieldZ;
        dec.regX     = insn[RegXLsb +: $bits(regIdxT)];
        dec.regY     = insn[RegYLsb +: $bits(regIdxT)];
        dec.op       = aluOpT'(insn[OpLsb +: $bits(aluOpT)]);
        dec.imm      = {{(WordWidth - ImmWidth){rawImm[ImmWidth-1]}}, rawImm};
        dec.illegal  = (insn == InsnIllegal);           // Halts the core
        dec.branch   = (fieldZ == RegPc) && !fieldStoring;
    end

endmodule

// ==== core/aluExec.sv ====
`timescale 1ns/1ps

module aluExec
    import isaPkg::*, sysPkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  en,
    input  aluOpT op,
    input  wordT  opX,
    input  wordT  opY,
    input  wordT  addend,
    output wordT  result
);

    logic signed [WordWidth-1:0] sx;
    logic signed [WordWidth-1:0] sy;
    wordT                        opOut;

    assign sx = opX;
    assign sy = opY;

    always_comb begin
        case (op)
            OpOr:     opOut = opX | opY;
            OpAnd:    opOut = opX & opY;
            OpAdd:    opOut = opX + opY;
            OpMul:    opOut = sx * sy;             // Low word of the product
            OpShl:    opOut = opX << opY;          // Full Y, large shifts give zero
            OpLt:     opOut = {WordWidth{sx < sy}};
            OpEq:     opOut = {WordWidth{opX == opY}};
            OpGt:     opOut = {WordWidth{sx > sy}};
            OpAndNot: opOut = opX & ~opY;
            OpXor:    opOut = opX ^ opY;
            OpSub:    opOut = opX - opY;
            OpXnor:   opOut = opX ~^ opY;
            OpShr:    opOut = opX >> opY;          // Logical
            OpNe:     opOut = {WordWidth{opX != opY}};
            OpResv4,
            OpResv15: opOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= '0;
        end else if (en) begin
            result <= opOut + addend;
        end
    end

endmodule

// ==== core/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore
    import isaPkg::*, sysPkg::*;
#(
    parameter wordT ResetVector = '0
) (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    en,
    output wordT    iAddr,
    input  wordT    iData,
    output dataBusT bus,
    input  wordT    dRead,
    output logic    halt
);

    logic [3:0] phaseRing;    // One-hot, current phase
    logic [3:0] enRing;       // Fills after reset, gates the phases
    logic [3:0] phase;
    logic       advance;
    wordT       insn;
    wordT       nextPc;
    wordT       fetchTarget;
    decodedT    dec;
    wordT       valueX;
    wordT       valueY;
    wordT       valueZ;
    wordT       rightOp;
    wordT       addend;
    wordT       aluResult;
    wordT       regWrData;

    assign phase       = phaseRing & enRing & {4{~halt}};
    assign advance     = |phase;
    assign fetchTarget = dec.branch ? aluResult : nextPc;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phaseRing <= 4'b0001;
            enRing    <= '0;       // Gives one startup cycle
            insn      <= InsnNoop;
            iAddr     <= ResetVector;
            nextPc    <= ResetVector + 1'b1;
            halt      <= 1'b0;
        end else if (en) begin
            enRing <= {enRing[2:0], 1'b1};
            if (advance) begin
                phaseRing <= {phaseRing[2:0], phaseRing[3]};
            end
            if (phase[0]) begin
                insn <= iData;     // Fetch
            end
            if (phase[1]) begin
                halt <= halt | dec.illegal;  // Sticky
            end
            if (phase[2]) begin
                iAddr  <= fetchTarget;
                nextPc <= fetchTarget + 1'b1;
            end
        end
    end

    insnDecode decode (
        .insn (insn),
        .dec  (dec)
    );

    // Immediate and Y swap roles between operand and addend
    assign rightOp = dec.immType ? dec.imm : valueY;
    assign addend  = dec.immType ? valueY : dec.imm;

    aluExec exec (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (en & phase[1]),
        .op      (dec.op),
        .opX     (valueX),
        .opY     (rightOp),
        .addend  (addend),
        .result  (aluResult)
    );

    always_comb begin
        bus.addr  = dec.derefRhs ? aluResult : valueZ;
        bus.wdata = dec.derefRhs ? valueZ : aluResult;
        bus.write = en & dec.storing & phase[2];
    end

    assign regWrData = dec.derefRhs ? dRead : aluResult;  // Load or ALU value

    regFile regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .en        (en),
        .writeEn   (phase[3] & ~dec.storing),
        .idxZ      (dec.regZ),
        .idxX      (dec.regX),
        .idxY      (dec.regY),
        .writeData (regWrData),
        .nextPc    (nextPc),
        .valueZ    (valueZ),
        .valueX    (valueX),
        .valueY    (valueY)
    );

    assert property (@(posedge clk) disable iff (!reset_n)
        bus.write |-> phaseRing[2] ##1 !bus.write)
        else $error("data write outside phase 2 or wider than one cycle");

    assert property (@(posedge clk) $fell(halt) |-> $past(!reset_n))
        else $error("halt dropped without reset");

endmodule

// ==== hw/progMem.sv ====
`timescale 1ns/1ps

module progMem
    import sysPkg::*;
#(
    parameter int MemDepthLog2 = 8
) (
    input  logic     clk,
    input  progLoadT load,
    input  wordT     rdAddr,
    output wordT     rdData
);

    localparam int Depth = 2 ** MemDepthLog2;

    wordT                    mem [Depth];
    logic [MemDepthLog2-1:0] wrIdx;
    logic [MemDepthLog2-1:0] rdIdx;

    // Upper address bits are ignored so addresses wrap
    assign wrIdx = load.addr[MemDepthLog2-1:0];
    assign rdIdx = rdAddr[MemDepthLog2-1:0];

    always_ff @(posedge clk) begin
        if (load.we) begin
            mem[wrIdx] <= load.data;  // Host load port
        end
    end

    assign rdData = mem[rdIdx];  // Asynchronous read

endmodule

// ==== hw/cpuSystem.sv ====
`timescale 1ns/1ps

module cpuSystem
    import sysPkg::*;
#(
    parameter wordT ResetVector  = '0,
    parameter int   MemDepthLog2 = 8
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     en,
    input  progLoadT load,
    output dataBusT  bus,
    input  wordT     dRead,
    output logic     halt
);

    wordT iAddr;
    wordT iData;

    cpuCore #(
        .ResetVector (ResetVector)
    ) core (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (en),
        .iAddr   (iAddr),
        .iData   (iData),
        .bus     (bus),
        .dRead   (dRead),
        .halt    (halt)
    );

    progMem #(
        .MemDepthLog2 (MemDepthLog2)
    ) imem (
        .clk    (clk),
        .load   (load),
        .rdAddr (iAddr),
        .rdData (iData)
    );

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int PeriodNs    = 8,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PeriodNs / 2) clk = ~clk;
        end
    end

    // Power-on reset, released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

// ==== bench/cpuSystemTb.sv ====
`timescale 1ns/1ps

module cpuSystemTb
    import isaPkg::*, sysPkg::*;
();

    localparam int ClkPeriodNs   = 8;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 600;
    localparam int WaitLimit     = 500;  // Cycles allowed for a halt or a store

    logic        clk;
    logic        porN;
    logic        softResetN;
    logic        dutResetN;
    logic        en;
    progLoadT    load;
    dataBusT     bus;
    wordT        dRead;
    logic        halt;
    wordT        dataMem [wordT];
    dataBusT     writeLog [$];
    logic [31:0] lfsrState;
    int          errors;
    int          passCount;
    int          failCount;

    clockGen #(.PeriodNs(ClkPeriodNs), .ResetCycles(16)) clocks (
        .clk     (clk),
        .reset_n (porN)
    );

    assign dutResetN = porN & softResetN;

    cpuSystem #(.ResetVector(32'h0), .MemDepthLog2(8)) dut (
        .clk     (clk),
        .reset_n (dutResetN),
        .en      (en),
        .load    (load),
        .bus     (bus),
        .dRead   (dRead),
        .halt    (halt)
    );

    function automatic wordT memRead(wordT addr);
        return dataMem.exists(addr) ? dataMem[addr] : 32'h0;
    endfunction

    // Data memory answers for whatever address the bus holds
    always @(negedge clk) begin
        dRead = memRead(bus.addr);
    end

    always @(posedge clk) begin
        if (bus.write === 1'b1) begin
            dataMem[bus.addr] = bus.wdata;
            writeLog.push_back(bus);
        end
    end

    function automatic logic [31:0] randomBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsrState[0]};  // One step per bit
        end
        return v;
    endfunction

    function automatic wordT encode(logic immType, logic storing, logic derefRhs, regIdxT z,
                                    regIdxT x, regIdxT y, aluOpT op, logic [11:0] imm);
        return {1'b0, immType, storing, derefRhs, z, x, y, op, imm};
    endfunction

    function automatic wordT addImm(regIdxT z, regIdxT x, logic [11:0] imm);
        return encode(1'b1, 1'b0, 1'b0, z, x, 4'd0, OpAdd, imm);
    endfunction

    function automatic wordT storeReg(regIdxT addrReg, regIdxT dataReg);
        return encode(1'b0, 1'b1, 1'b0, addrReg, dataReg, 4'd0, OpOr, 12'h000);
    endfunction

    function automatic wordT sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic dataBusT expectWrite(wordT addr, wordT data);
        dataBusT b;
        b.addr  = addr;
        b.wdata = data;
        b.write = 1'b1;
        return b;
    endfunction

    // Reference results of the 16 opcodes, before the addend
    function automatic wordT refOp(aluOpT op, wordT a, wordT b);
        case (op)
            OpOr:     return a | b;
            OpAnd:    return a & b;
            OpAdd:    return a + b;
            OpMul:    return a * b;
            OpShl:    return (b > 32'd31) ? 32'h0 : a << b[4:0];
            OpLt:     return ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'h0;
            OpEq:     return (a == b) ? 32'hffff_ffff : 32'h0;
            OpGt:     return ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'h0;
            OpAndNot: return a & ~b;
            OpXor:    return a ^ b;
            OpSub:    return a - b;
            OpXnor:   return ~(a ^ b);
            OpShr:    return (b > 32'd31) ? 32'h0 : a >> b[4:0];
            OpNe:     return (a != b) ? 32'hffff_ffff : 32'h0;
            default:  return 32'h0;  // Reserved
        endcase
    endfunction

    task automatic checkWord(string what, wordT got, wordT exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkBus(string what, dataBusT got, dataBusT exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is addr %h data %h, expected addr %h data %h",
                     $time, what, got.addr, got.wdata, exp.addr, exp.wdata);
            errors++;
        end
    endtask

    task automatic checkWrites(input dataBusT exp[$]);
        if (writeLog.size() != exp.size()) begin
            $display("Expected %0d data writes but saw %0d", exp.size(), writeLog.size());
            errors++;
        end
        foreach (exp[i]) begin
            if (i < writeLog.size()) begin
                checkBus($sformatf("write %0d", i), writeLog[i], exp[i]);
            end
        end
    endtask

    // Program goes in while the core is stopped, then a reset starts it
    task automatic loadAndStart(input wordT words[$]);
        @(negedge clk);
        en = 1'b0;
        softResetN = 1'b0;
        dataMem.delete();
        writeLog.delete();
        foreach (words[i]) begin
            load = '{we: 1'b1, addr: wordT'(i), data: words[i]};
            @(negedge clk);
        end
        load.we = 1'b0;
        repeat (2) @(negedge clk);
        softResetN = 1'b1;
        en = 1'b1;
    endtask

    task automatic waitHalt();
        int waited;
        waited = 0;
        while (halt !== 1'b1 && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (halt !== 1'b1) begin
            $display("Halt missing, core still running after %0d cycles", WaitLimit);
            errors++;
        end
    endtask

    task automatic waitWrites(int count);
        int waited;
        waited = 0;
        while (writeLog.size() < count && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (writeLog.size() < count) begin
            $display("No store seen, %0d of %0d writes arrived", writeLog.size(), count);
            errors++;
        end
    endtask

    task automatic finishTest(string name);
        if (errors == 0) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    task automatic testAluReg();
        wordT        p[$];
        dataBusT     exp[$];
        logic [11:0] a;
        logic [11:0] b;
        a = 12'(randomBits(12));
        b = 12'(randomBits(12));
        p.push_back(addImm(4'd1, 4'd0, a));
        p.push_back(addImm(4'd2, 4'd0, b));
        p.push_back(addImm(4'd3, 4'd0, 12'h100));
        for (int k = 0; k < 16; k++) begin
            p.push_back(encode(1'b0, 1'b0, 1'b0, 4'd4, 4'd1, 4'd2, aluOpT'(k), 12'h000));
            p.push_back(encode(1'b1, 1'b1, 1'b1, 4'd4, 4'd3, 4'd0, OpAdd, 12'(k)));
            exp.push_back(expectWrite(32'h100 + k, refOp(aluOpT'(k), sext12(a), sext12(b))));
        end
        p.push_back(InsnIllegal);
        loadAndStart(p);
        waitHalt();
        checkWrites(exp);
        finishTest("register-type ALU");
    endtask

    task automatic testAluImm();
        wordT        p[$];
        logic [11:0] c;
        logic [11:0] d;
        wordT        x;
        wordT        y;
        c = 12'(randomBits(12));
        d = 12'(randomBits(12));
        x = sext12(c);
        y = sext12(d);
        p.push_back(addImm(4'd5, 4'd0, c));
        p.push_back(addImm(4'd6, 4'd0, d));
        p.push_back(addImm(4'd7, 4'd0, 12'h200));
        p.push_back(encode(1'b1, 1'b0, 1'b0, 4'd8, 4'd5, 4'd6, OpAdd, 12'h800));
        p.push_back(encode(1'b1, 1'b0, 1'b0, 4'd9, 4'd5, 4'd6, OpSub, 12'hfff));
        p.push_back(encode(1'b1, 1'b0, 1'b0, 4'd10, 4'd5, 4'd6, OpAnd, 12'hf0f));
        p.push_back(encode(1'b0, 1'b0, 1'b0, 4'd11, 4'd5, 4'd6, OpXor, 12'hff0));
        for (int k = 0; k < 4; k++) begin
            p.push_back(encode(1'b1, 1'b1, 1'b1, regIdxT'(8 + k), 4'd7, 4'd0, OpAdd, 12'(k)));
        end
        p.push_back(InsnIllegal);
        loadAndStart(p);
        waitHalt();
        checkWord("x plus -2048 plus y", memRead(32'h200), x - 32'd2048 + y);
        checkWord("x minus -1 plus y", memRead(32'h201), x + 32'd1 + y);
        checkWord("x and ~0xf0 plus y", memRead(32'h202), (x & 32'hffff_ff0f) + y);
        checkWord("x xor y minus 16", memRead(32'h203), (x ^ y) - 32'd16);
        finishTest("immediate-type operations");
    endtask

    task automatic testStoreLoad();
        wordT        p[$];
        dataBusT     exp[$];
        logic [11:0] e;
        wordT        v;
        e = 12'(randomBits(12));
        v = sext12(e);
        p.push_back(addImm(4'd1, 4'd0, 12'h300));
        p.push_back(addImm(4'd2, 4'd0, e));
        p.push_back(encode(1'b1, 1'b1, 1'b0, 4'd1, 4'd2, 4'd0, OpAdd, 12'h005));  // [r1] = r2 + 5
        p.push_back(encode(1'b1, 1'b1, 1'b1, 4'd2, 4'd1, 4'd0, OpAdd, 12'h004));  // [r1 + 4] = r2
        p.push_back(encode(1'b1, 1'b0, 1'b1, 4'd3, 4'd1, 4'd0, OpAdd, 12'h000));  // Load r3
        p.push_back(encode(1'b1, 1'b1, 1'b1, 4'd3, 4'd1, 4'd0, OpAdd, 12'h008));
        p.push_back(encode(1'b1, 1'b0, 1'b1, 4'd4, 4'd1, 4'd0, OpAdd, 12'h004));  // Load r4
        p.push_back(storeReg(4'd1, 4'd4));
        p.push_back(InsnIllegal);
        exp.push_back(expectWrite(32'h300, v + 32'd5));
        exp.push_back(expectWrite(32'h304, v));
        exp.push_back(expectWrite(32'h308, v + 32'd5));
        exp.push_back(expectWrite(32'h300, v));
        loadAndStart(p);
        waitHalt();
        checkWrites(exp);
        finishTest("store modes and load");
    endtask

    task automatic testBranch();
        wordT    p[$];
        dataBusT exp[$];
        p.push_back(addImm(4'd1, 4'd0, 12'h400));
        p.push_back(addImm(4'd2, 4'd0, 12'h0aa));
        p.push_back(addImm(4'd15, 4'd0, 12'd5));   // Absolute jump to word 5
        p.push_back(storeReg(4'd1, 4'd2));
        p.push_back(InsnIllegal);
        p.push_back(addImm(4'd2, 4'd2, 12'd1));
        p.push_back(storeReg(4'd1, 4'd2));
        p.push_back(addImm(4'd15, 4'd15, 12'd1));  // Next pc plus one skips word 8
        p.push_back(storeReg(4'd1, 4'd0));
        p.push_back(InsnIllegal);
        exp.push_back(expectWrite(32'h400, 32'h0ab));
        loadAndStart(p);
        waitHalt();
        checkWrites(exp);
        finishTest("branch");
    endtask

    task automatic testIllegal();
        wordT    p[$];
        dataBusT exp[$];
        p.push_back(addImm(4'd1, 4'd0, 12'h500));
        p.push_back(addImm(4'd2, 4'd0, 12'h055));
        p.push_back(storeReg(4'd1, 4'd2));
        p.push_back(InsnIllegal);
        p.push_back(storeReg(4'd2, 4'd1));
        exp.push_back(expectWrite(32'h500, 32'h055));
        loadAndStart(p);
        waitHalt();
        repeat (40) @(negedge clk);
        if (halt !== 1'b1) begin
            $display("Halt did not stay high after the illegal instruction");
            errors++;
        end
        checkWrites(exp);
        finishTest("illegal instruction");
    endtask

    task automatic testFreeze();
        wordT    p[$];
        dataBusT exp[$];
        p.push_back(addImm(4'd1, 4'd0, 12'h600));
        p.push_back(addImm(4'd2, 4'd0, 12'h000));
        for (int k = 0; k < 3; k++) begin
            p.push_back(addImm(4'd2, 4'd2, 12'h011));
            p.push_back(storeReg(4'd1, 4'd2));
            p.push_back(addImm(4'd1, 4'd1, 12'h001));
            exp.push_back(expectWrite(32'h600 + k, 32'h11 * (k + 1)));
        end
        p.push_back(InsnIllegal);
        loadAndStart(p);
        waitWrites(1);
        en = 1'b0;  // Stall right after the first store
        repeat (50) @(negedge clk);
        if (writeLog.size() != 1 || halt !== 1'b0) begin
            $display("Core did not hold still while en was low");
            errors++;
        end
        en = 1'b1;
        waitHalt();
        checkWrites(exp);
        finishTest("freeze");
    endtask

    initial begin
        en         = 1'b0;
        softResetN = 1'b1;
        load       = '0;
        dRead      = '0;
        lfsrState  = 32'h967330a4;
        errors     = 0;
        passCount  = 0;
        failCount  = 0;
        wait (porN === 1'b1);
        testAluReg();
        testAluImm();
        testStoreLoad();
        testBranch();
        testIllegal();
        testFreeze();
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(NumTests * CyclesPerTest * ClkPeriodNs);
        $display("Watchdog expired after %0d cycles, the run is stuck", NumTests * CyclesPerTest);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== tinyCore.f ====
common/sysPkg.sv
common/isaPkg.sv
core/regFile.sv
core/insnDecode.sv
core/aluExec.sv
core/cpuCore.sv
hw/progMem.sv
hw/cpuSystem.sv
bench/clockGen.sv
bench/cpuSystemTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpuSystemTb -Mdir obj_dir -o simv -f tinyCore.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
